// File: include/playfield_config.svh
`ifndef PLAYFIELD_CONFIG_SVH
`define PLAYFIELD_CONFIG_SVH

// board size, row 0 is the top
`define PF_ROWS 22
`define PF_COLS 10

// index widths
`define ROW_W 5
`define COL_W 4

// one tile code
`define TILE_W 4

// running lines total, wraps
`define LINES_W 10

`endif

// File: hdl/tetris_pkg.sv
`include "playfield_config.svh"

package tetris_pkg;

    // contents of one board cell
    typedef enum logic [`TILE_W-1:0] {
        BLANK   = 4'd0,
        I       = 4'd1,
        O       = 4'd2,
        T       = 4'd3,
        J       = 4'd4,
        L       = 4'd5,
        S       = 4'd6,
        Z       = 4'd7,
        GHOST   = 4'd8,
        GARBAGE = 4'd9
    } tile_type_t;

endpackage

// File: hdl/piece_lock_writer.sv
`timescale 1ns/1ps

`include "playfield_config.svh"

module piece_lock_writer
    import tetris_pkg::*;
(
    input  logic                              lock,
    input  logic [`ROW_W-1:0]                 cell_rows [4],
    input  logic [`COL_W-1:0]                 cell_cols [4],
    input  tile_type_t                        piece_type,
    input  logic                              settling,
    output logic [`PF_ROWS-1:0][`PF_COLS-1:0] cell_we,
    output tile_type_t                        write_tile
);

    logic lock_ok;

    // only a real tetromino locks, and only into a stable board
    always_comb begin
        lock_ok = lock && !settling;
        if (piece_type == BLANK || piece_type == GHOST) begin
            lock_ok = 1'b0;
        end
    end

    // one-hot per cell, off-board cells dropped
    always_comb begin
        cell_we = '0;
        if (lock_ok) begin
            for (int k = 0; k < 4; k++) begin
                if (cell_rows[k] < `PF_ROWS && cell_cols[k] < `PF_COLS) begin
                    cell_we[cell_rows[k]][cell_cols[k]] = 1'b1;
                end
            end
        end
    end

    assign write_tile = piece_type;

endmodule

// File: hdl/playfield_store.sv
`timescale 1ns/1ps

`include "playfield_config.svh"

module playfield_store
    import tetris_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              game_start,
    input  logic [`PF_ROWS-1:0][`PF_COLS-1:0] cell_we,
    input  tile_type_t                        write_tile,
    input  logic                              load_garbage,
    input  logic [`COL_W-1:0]                 hole_col,
    input  logic [`ROW_W-1:0]                 rd_row,
    output tile_type_t                        rd_tiles [`PF_COLS],
    output logic [`PF_ROWS-1:0]               full_rows,
    output logic                              settling,
    output logic                              cleared
);

    tile_type_t          tiles [`PF_ROWS][`PF_COLS];
    logic [`PF_ROWS-1:0] row_empty;
    logic [`PF_ROWS-1:0] above_filled;
    logic [`PF_ROWS-1:0] pull_down;
    logic                garbage_go;

    // ghost counts as a hole
    always_comb begin
        for (int i = 0; i < `PF_ROWS; i++) begin
            full_rows[i] = 1'b1;
            row_empty[i] = 1'b1;
            for (int j = 0; j < `PF_COLS; j++) begin
                if (tiles[i][j] == BLANK || tiles[i][j] == GHOST) begin
                    full_rows[i] = 1'b0;
                end else begin
                    row_empty[i] = 1'b0;
                end
            end
        end
    end

    // any tiles somewhere higher up
    always_comb begin
        above_filled[0] = 1'b0;
        for (int i = 1; i < `PF_ROWS; i++) begin
            above_filled[i] = above_filled[i-1] | ~row_empty[i-1];
        end
    end

    // a full row above is cleared first, so it never falls and counts twice
    always_comb begin
        pull_down[0] = 1'b0;
        for (int i = 1; i < `PF_ROWS; i++) begin
            pull_down[i] = row_empty[i] & ~row_empty[i-1] & ~full_rows[i-1];
        end
    end

    assign settling   = (|full_rows) || (|(row_empty & above_filled));
    assign cleared    = (|full_rows) && !game_start;
    assign garbage_go = load_garbage && !settling && (cell_we == '0);

    always_ff @(posedge clk) begin
        if (!rst_n || game_start) begin
            for (int i = 0; i < `PF_ROWS; i++) begin
                tiles[i] <= '{default: BLANK};
            end
        end else begin
            for (int i = 0; i < `PF_ROWS; i++) begin
                if (full_rows[i]) begin
                    tiles[i] <= '{default: BLANK};
                end
            end

            // one row step per cycle
            for (int i = 1; i < `PF_ROWS; i++) begin
                if (pull_down[i]) begin
                    tiles[i]   <= tiles[i-1];
                    tiles[i-1] <= '{default: BLANK};
                end
            end

            for (int i = 0; i < `PF_ROWS; i++) begin
                for (int j = 0; j < `PF_COLS; j++) begin
                    if (cell_we[i][j]) begin
                        tiles[i][j] <= write_tile;
                    end
                end
            end

            // push up from the bottom, top row is lost
            if (garbage_go) begin
                for (int i = 0; i < `PF_ROWS - 1; i++) begin
                    tiles[i] <= tiles[i+1];
                end
                for (int j = 0; j < `PF_COLS; j++) begin
                    tiles[`PF_ROWS-1][j] <= (j == hole_col) ? BLANK : GARBAGE;
                end
            end
        end
    end

    // read port, rows past the bottom read blank
    always_comb begin
        rd_tiles = '{default: BLANK};
        if (rd_row < `PF_ROWS) begin
            rd_tiles = tiles[rd_row];
        end
    end

endmodule

// File: hdl/line_tally.sv
`timescale 1ns/1ps

`include "playfield_config.svh"

module line_tally (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                game_start,
    input  logic [`PF_ROWS-1:0] full_rows,
    input  logic                cleared,
    output logic [`LINES_W-1:0] lines_cleared
);

    logic [`LINES_W-1:0] row_count;

    // popcount of rows going away this cycle
    always_comb begin
        row_count = '0;
        for (int i = 0; i < `PF_ROWS; i++) begin
            row_count = row_count + {{(`LINES_W-1){1'b0}}, full_rows[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || game_start) begin
            lines_cleared <= '0;
        end else if (cleared) begin
            lines_cleared <= lines_cleared + row_count;
        end
    end

endmodule

// File: hdl/playfield_core.sv
`timescale 1ns/1ps

`include "playfield_config.svh"

module playfield_core
    import tetris_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                game_start,
    input  logic                lock,
    input  logic [`ROW_W-1:0]   cell_rows [4],
    input  logic [`COL_W-1:0]   cell_cols [4],
    input  tile_type_t          piece_type,
    input  logic                load_garbage,
    input  logic [`COL_W-1:0]   hole_col,
    input  logic [`ROW_W-1:0]   rd_row,
    output tile_type_t          rd_tiles [`PF_COLS],
    output logic                settling,
    output logic [`LINES_W-1:0] lines_cleared
);

    logic [`PF_ROWS-1:0][`PF_COLS-1:0] cell_we;
    tile_type_t                        write_tile;
    logic [`PF_ROWS-1:0]               full_rows;
    logic                              cleared;

    piece_lock_writer i_writer (
        .lock       (lock),
        .cell_rows  (cell_rows),
        .cell_cols  (cell_cols),
        .piece_type (piece_type),
        .settling   (settling),
        .cell_we    (cell_we),
        .write_tile (write_tile)
    );

    playfield_store i_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .game_start   (game_start),
        .cell_we      (cell_we),
        .write_tile   (write_tile),
        .load_garbage (load_garbage),
        .hole_col     (hole_col),
        .rd_row       (rd_row),
        .rd_tiles     (rd_tiles),
        .full_rows    (full_rows),
        .settling     (settling),
        .cleared      (cleared)
    );

    line_tally i_tally (
        .clk           (clk),
        .rst_n         (rst_n),
        .game_start    (game_start),
        .full_rows     (full_rows),
        .cleared       (cleared),
        .lines_cleared (lines_cleared)
    );

endmodule

// File: tests/playfield_core_assert.sv
`timescale 1ns/1ps

`include "playfield_config.svh"

module playfield_core_assert
    import tetris_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic                game_start,
    input logic                settling,
    input logic [`LINES_W-1:0] lines_cleared,
    input tile_type_t          rd_tiles [`PF_COLS]
);

    int fail_count = 0;

    // board is empty right after reset or start
    assert property (@(posedge clk) (!rst_n || game_start) |=> !settling)
        else begin
            $error("settling high in the cycle after reset or start");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        !$past(game_start) |-> lines_cleared >= $past(lines_cleared))
        else begin
            $error("lines total went down without a start");
            fail_count++;
        end

    // a full row keeps the board unsettled until it is cleared
    assert property (@(posedge clk) disable iff (!rst_n)
        (!$past(game_start) && lines_cleared != $past(lines_cleared)) |-> $past(settling))
        else begin
            $error("lines total changed while settling was low");
            fail_count++;
        end

    for (genvar j = 0; j < `PF_COLS; j++) begin : g_no_ghost
        assert property (@(posedge clk) disable iff (!rst_n) rd_tiles[j] != GHOST)
            else begin
                $error("ghost tile read back in column %0d", j);
                fail_count++;
            end
    end

endmodule

bind playfield_core playfield_core_assert i_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .game_start    (game_start),
    .settling      (settling),
    .lines_cleared (lines_cleared),
    .rd_tiles      (rd_tiles)
);

// File: tests/playfield_core_tb.sv
`timescale 1ns/1ps

`include "playfield_config.svh"

module playfield_core_tb
    import tetris_pkg::*;
();

    logic                clk;
    logic                rst_n;
    logic                game_start;
    logic                lock;
    logic [`ROW_W-1:0]   cell_rows [4];
    logic [`COL_W-1:0]   cell_cols [4];
    tile_type_t          piece_type;
    logic                load_garbage;
    logic [`COL_W-1:0]   hole_col;
    logic [`ROW_W-1:0]   rd_row;
    tile_type_t          rd_tiles [`PF_COLS];
    logic                settling;
    logic [`LINES_W-1:0] lines_cleared;

    string       vec_lines [$];
    bit          loaded;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;
    logic [31:0] lcg_state;

    playfield_core i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .game_start    (game_start),
        .lock          (lock),
        .cell_rows     (cell_rows),
        .cell_cols     (cell_cols),
        .piece_type    (piece_type),
        .load_garbage  (load_garbage),
        .hole_col      (hole_col),
        .rd_row        (rd_row),
        .rd_tiles      (rd_tiles),
        .settling      (settling),
        .lines_cleared (lines_cleared)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic idle_gap();
        lcg_state = lcg_next(lcg_state);
        repeat (lcg_state[17:16]) @(posedge clk);
    endtask

    task automatic compare_tile(input int row, input int col,
                                input tile_type_t exp_tile, input tile_type_t act_tile);
        checks++;
        if (act_tile !== exp_tile) begin
            errors++;
            test_errors++;
            $display("FAIL t=%0t row %0d col %0d expected %0d got %0d",
                     $time, row, col, exp_tile, act_tile);
        end
    endtask

    task automatic compare_total(input logic [`LINES_W-1:0] exp_total,
                                 input logic [`LINES_W-1:0] act_total);
        checks++;
        if (act_total !== exp_total) begin
            errors++;
            test_errors++;
            $display("FAIL t=%0t lines total expected %0d got %0d",
                     $time, exp_total, act_total);
        end
    endtask

    // rd_tiles is combinational, read it mid-cycle
    task automatic select_row(input int row);
        @(posedge clk);
        rd_row <= row[`ROW_W-1:0];
        @(negedge clk);
    endtask

    task automatic wait_settle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (settling === 1'b1 && cycles < `PF_ROWS + 10) begin
            @(negedge clk);
            cycles++;
        end
        if (settling !== 1'b0) begin
            errors++;
            test_errors++;
            $display("settling did not fall within %0d cycles at t=%0t", cycles, $time);
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("%s: passed", test_name);
            end else begin
                tests_failed++;
                $display("%s: failed with %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    task automatic run_op(input string line);
        string op;
        string name;
        int    a [11];
        void'($sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", op, a[0], a[1], a[2],
                      a[3], a[4], a[5], a[6], a[7], a[8], a[9], a[10]));
        case (op)
            "test": begin
                void'($sscanf(line, "%s %s", op, name));
                close_test();
                test_name = name;
            end
            "start": begin
                @(posedge clk);
                game_start <= 1'b1;
                @(posedge clk);
                game_start <= 1'b0;
            end
            "lock": begin
                @(posedge clk);
                for (int k = 0; k < 4; k++) begin
                    cell_rows[k] <= a[2*k][`ROW_W-1:0];
                    cell_cols[k] <= a[2*k+1][`COL_W-1:0];
                end
                piece_type <= tile_type_t'(a[8][`TILE_W-1:0]);
                lock       <= 1'b1;
                @(posedge clk);
                lock <= 1'b0;
            end
            "garbage": begin
                @(posedge clk);
                hole_col     <= a[0][`COL_W-1:0];
                load_garbage <= 1'b1;
                @(posedge clk);
                load_garbage <= 1'b0;
            end
            "settle": wait_settle();
            "row": begin
                select_row(a[0]);
                for (int j = 0; j < `PF_COLS; j++) begin
                    compare_tile(a[0], j, tile_type_t'(a[j+1][`TILE_W-1:0]), rd_tiles[j]);
                end
            end
            "blank": begin
                for (int r = a[0]; r <= a[1]; r++) begin
                    select_row(r);
                    for (int j = 0; j < `PF_COLS; j++) begin
                        compare_tile(r, j, BLANK, rd_tiles[j]);
                    end
                end
            end
            "total": begin
                @(negedge clk);
                compare_total(a[0][`LINES_W-1:0], lines_cleared);
            end
            default: begin
                errors++;
                $display("unknown operation in vectors file: %s", line);
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        rst_n        = 1'b0;
        game_start   = 1'b0;
        lock         = 1'b0;
        piece_type   = BLANK;
        load_garbage = 1'b0;
        hole_col     = '0;
        rd_row       = '0;
        for (int k = 0; k < 4; k++) begin
            cell_rows[k] = '0;
            cell_cols[k] = '0;
        end
        lcg_state = 32'hcce02a91;
        test_name = "";

        fd = $fopen("tests/playfield_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/playfield_vectors.txt");
        end else begin
            while ($fgets(line, fd)) begin
                // skip comments and blank lines
                if (line.len() > 1 && line[0] != "#") begin
                    vec_lines.push_back(line);
                end
            end
            $fclose(fd);
            loaded = 1'b1;
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        foreach (vec_lines[n]) begin
            idle_gap();
            run_op(vec_lines[n]);
        end
        close_test();
        @(posedge clk);

        errors += i_dut.i_assert.fail_count;
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, i_dut.i_assert.fail_count);
        if (errors == 0 && tests_failed == 0 && checks > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // worst op is a full board scan plus gap
    initial begin
        wait (loaded);
        #(vec_lines.size() * (`PF_ROWS + 10) * 10);
        $display("run timed out before all vector lines were done");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/playfield_vectors.txt
# op operands, decimal: lock r0 c0 r1 c1 r2 c2 r3 c3 type | garbage hole | settle | start
# row r t0..t9 | blank first_row last_row | total n | test name
test reset_start
blank 0 21
total 0
test locking
lock 21 0 21 1 21 2 20 2 5
settle
row 20 0 0 5 0 0 0 0 0 0 0
row 21 5 5 5 0 0 0 0 0 0 0
lock 19 5 19 6 18 5 18 6 8
lock 22 0 25 3 31 9 0 10 3
settle
blank 0 19
row 20 0 0 5 0 0 0 0 0 0 0
row 21 5 5 5 0 0 0 0 0 0 0
total 0
start
blank 0 21
total 0
test clear_one
lock 21 0 21 1 21 2 20 2 5
lock 21 3 21 4 21 5 21 6 1
lock 21 7 21 8 21 9 20 9 4
settle
blank 0 20
row 21 0 0 5 0 0 0 0 0 0 4
total 1
test clear_two
start
lock 20 2 20 3 21 2 21 3 2
lock 20 4 20 5 21 4 21 5 2
lock 20 6 20 7 21 6 21 7 2
lock 20 8 20 9 21 8 21 9 2
lock 19 1 19 2 20 1 21 1 5
lock 18 0 19 0 20 0 21 0 1
settle
blank 0 19
row 20 1 0 0 0 0 0 0 0 0 0
row 21 1 5 5 0 0 0 0 0 0 0
total 2
test garbage
garbage 4
blank 0 18
row 19 1 0 0 0 0 0 0 0 0 0
row 20 1 5 5 0 0 0 0 0 0 0
row 21 9 9 9 9 0 9 9 9 9 9
total 2
lock 21 4 20 3 20 4 20 5 3
settle
blank 0 19
row 20 1 0 0 0 0 0 0 0 0 0
row 21 1 5 5 3 3 3 0 0 0 0
total 3

// File: files.f
+incdir+include
hdl/tetris_pkg.sv
hdl/piece_lock_writer.sv
hdl/playfield_store.sv
hdl/line_tally.sv
hdl/playfield_core.sv
tests/playfield_core_assert.sv
tests/playfield_core_tb.sv
